/* run_sim.sh */
#!/bin/sh
# Build and run the trace register testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module trace_reg_tb -f trace_reg_block.f -o trace_reg_sim \
   && ./obj_dir/trace_reg_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation PASSED"; exit 0; }

/* trace_reg_block.f */
+incdir+verification
verilog/trace_reg_pkg.sv
verilog/trace_reg_decode.sv
verilog/match_rule_regs.sv
verilog/trace_ctrl_regs.sv
verilog/trace_read_mux.sv
verilog/trace_reg_block.sv
verification/trace_reg_tb.sv

/* verification/trace_reg_tb_tasks.svh */
// Testbench helpers included inside trace_reg_tb; relies on its signals and shadow registers
`ifndef TRACE_REG_TB_TASKS_SVH
`define TRACE_REG_TB_TASKS_SVH
`default_nettype none

   ////////////////////
   // Bus and model
   ////////////////////

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic trace_reg_pkg::byte_t random_byte();
      trace_reg_pkg::byte_t value;
      logic                 feedback;
      value = '0;
      for (int i = 0; i < 8; i++) begin
         value      = {value[6:0], lfsr_state[31]};
         feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], feedback};
      end
      return value;
   endfunction

   function automatic trace_reg_pkg::byte_t in_window(input trace_reg_pkg::reg_addr_t offset);
      return {WINDOW, offset};
   endfunction

   task automatic model_reset();
      for (int r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin
         sh_pattern[3'(r)] = trace_reg_pkg::PATTERN_RESET;
         sh_mask[3'(r)]    = trace_reg_pkg::MASK_RESET;
      end
      sh_ctrl.pattern_enable      = trace_reg_pkg::ENABLE_RESET;
      sh_ctrl.pattern_trig_enable = trace_reg_pkg::ENABLE_RESET;
      sh_ctrl.trace_width         = trace_reg_pkg::TRACE_WIDTH_RESET;
      sh_ctrl.capture_raw         = trace_reg_pkg::CAPTURE_RAW_RESET;
      sh_ctrl.record_syncs        = trace_reg_pkg::RECORD_SYNCS_RESET;
   endtask

   // Expected byte from the shadow registers and the driven inputs
   function automatic trace_reg_pkg::byte_t expected_byte(
      input trace_reg_pkg::byte_t address, input trace_reg_pkg::byte_idx_t count, input logic valid);
      string                name;
      trace_reg_pkg::lane_t lane;
      int                   offset;
      name   = "ArmTrace";
      lane   = count[2:0];
      offset = int'(address[5:0]);
      if (!valid || address[7:6] != WINDOW) begin
         return '0;
      end
      case (address[5:0])
         trace_reg_pkg::REG_NAME:                return name[lane];
         trace_reg_pkg::REG_REV:                 return trace_reg_pkg::TRACE_REV;
         trace_reg_pkg::REG_PATTERN_ENABLE:      return sh_ctrl.pattern_enable;
         trace_reg_pkg::REG_PATTERN_TRIG_ENABLE: return sh_ctrl.pattern_trig_enable;
         trace_reg_pkg::REG_TRACE_WIDTH:         return {5'd0, sh_ctrl.trace_width};
         trace_reg_pkg::REG_CAPTURE_RAW:         return {7'd0, sh_ctrl.capture_raw};
         trace_reg_pkg::REG_RECORD_SYNCS:        return {7'd0, sh_ctrl.record_syncs};
         trace_reg_pkg::REG_SYNCHRONIZED:        return {7'd0, synchronized};
         trace_reg_pkg::REG_TRACE_COUNT:         return trace_counts[3'd7 - lane];
         default: begin
         end
      endcase
      if (offset >= 16 && offset < 24) begin   // Patterns of rules 0..7
         return sh_pattern[3'(offset - 16)][{lane, 3'b000} +: 8];
      end
      if (offset >= 24 && offset < 32) begin
         return sh_mask[3'(offset - 24)][{lane, 3'b000} +: 8];
      end
      return '0;
   endfunction

   task automatic bus_write(input trace_reg_pkg::byte_t address, input trace_reg_pkg::byte_idx_t count,
                            input trace_reg_pkg::byte_t data, input logic valid);
      int offset;
      @(negedge usb_clk);
      reg_address   = address;
      reg_bytecnt   = count;
      write_data    = data;
      reg_addrvalid = valid;
      reg_read      = 1'b0;
      reg_write     = 1'b1;
      offset        = int'(address[5:0]);
      if (valid && address[7:6] == WINDOW) begin
         case (address[5:0])
            trace_reg_pkg::REG_PATTERN_ENABLE:      sh_ctrl.pattern_enable = data;
            trace_reg_pkg::REG_PATTERN_TRIG_ENABLE: sh_ctrl.pattern_trig_enable = data;
            trace_reg_pkg::REG_TRACE_WIDTH:         sh_ctrl.trace_width = data[2:0];
            trace_reg_pkg::REG_CAPTURE_RAW:         sh_ctrl.capture_raw = data[0];
            trace_reg_pkg::REG_RECORD_SYNCS:        sh_ctrl.record_syncs = data[0];
            default: begin
               if (offset >= 16 && offset < 24) begin
                  sh_pattern[3'(offset - 16)][{count[2:0], 3'b000} +: 8] = data;
               end
               else if (offset >= 24 && offset < 32) begin
                  sh_mask[3'(offset - 24)][{count[2:0], 3'b000} +: 8] = data;
               end
            end
         endcase
      end
   endtask

   task automatic bus_read(input trace_reg_pkg::byte_t address, input trace_reg_pkg::byte_idx_t count,
                           input logic valid);
      @(negedge usb_clk);
      reg_address   = address;
      reg_bytecnt   = count;
      reg_addrvalid = valid;
      reg_write     = 1'b0;
      reg_read      = 1'b1;
      exp_q.push_back(expected_byte(address, count, valid));
   endtask

   task automatic bus_idle();
      @(negedge usb_clk);
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
   endtask

   task automatic read_register_map();
      for (int a = 0; a < 32; a++) begin
         for (int b = 0; b < 8; b++) begin
            bus_read(in_window(6'(a)), 7'(b), 1'b1);
         end
      end
      bus_idle();
   endtask

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_byte(input string name, input trace_reg_pkg::byte_t got,
                             input trace_reg_pkg::byte_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_pattern(input string name, input trace_reg_pkg::pattern_t got,
                                input trace_reg_pkg::pattern_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_ctrl(input string name, input trace_reg_pkg::trace_ctrl_t got,
                             input trace_reg_pkg::trace_ctrl_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_rules();
      for (int r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin
         check_pattern($sformatf("trace_patterns[%0d]", r), trace_patterns[3'(r)], sh_pattern[3'(r)]);
         check_pattern($sformatf("trace_masks[%0d]", r), trace_masks[3'(r)], sh_mask[3'(r)]);
      end
   endtask

`default_nettype wire
`endif

/* verification/trace_reg_tb.sv */
// Testbench of trace_reg_block at default parameters; checks assume registered read data
`default_nettype none

module trace_reg_tb;

   localparam int         CLK_PERIOD   = 10;
   localparam int         RESET_CYCLES = 5;
   localparam logic [1:0] WINDOW       = 2'd2;     // Default BLOCK_SELECT
   localparam int         MAP_READS    = 32 * 8;   // Offsets 0..31, every lane
   // Two map sweeps, 128 rule byte writes, then control, resync and window tests
   localparam int         TEST_CYCLES  = RESET_CYCLES + 2 * MAP_READS + 128 + 120;

   logic                       usb_clk;
   logic                       reset_i;
   trace_reg_pkg::byte_t       reg_address;
   trace_reg_pkg::byte_idx_t   reg_bytecnt;
   trace_reg_pkg::byte_t       write_data;
   logic                       reg_read;
   logic                       reg_write;
   logic                       reg_addrvalid;
   trace_reg_pkg::byte_t       read_data;
   logic                       selected;
   trace_reg_pkg::trace_ctrl_t trace_ctrl;
   trace_reg_pkg::pattern_t    trace_patterns [trace_reg_pkg::MAX_RULES];
   trace_reg_pkg::pattern_t    trace_masks [trace_reg_pkg::MAX_RULES];
   logic                       reset_sync;
   trace_reg_pkg::byte_t       trace_counts [trace_reg_pkg::MAX_RULES];
   logic                       synchronized;

   // Shadow registers of the reference model
   trace_reg_pkg::pattern_t    sh_pattern [trace_reg_pkg::MAX_RULES];
   trace_reg_pkg::pattern_t    sh_mask [trace_reg_pkg::MAX_RULES];
   trace_reg_pkg::trace_ctrl_t sh_ctrl;
   trace_reg_pkg::byte_t       exp_q [$];   // Expected read bytes, oldest first
   logic [31:0]                lfsr_state;
   int                         n_checks;
   int                         n_errors;

   trace_reg_block i_dut (
      .usb_clk        (usb_clk),
      .reset_i        (reset_i),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .write_data     (write_data),
      .reg_read       (reg_read),
      .reg_write      (reg_write),
      .reg_addrvalid  (reg_addrvalid),
      .read_data      (read_data),
      .selected       (selected),
      .trace_ctrl     (trace_ctrl),
      .trace_patterns (trace_patterns),
      .trace_masks    (trace_masks),
      .reset_sync     (reset_sync),
      .trace_counts   (trace_counts),
      .synchronized   (synchronized)
   );

   initial usb_clk = 1'b0;
   always #(CLK_PERIOD / 2) usb_clk = ~usb_clk;

   ////////////////////
   // Bus checker
   ////////////////////

   // Selection checked at each rising edge, registered read byte at the next falling edge
   initial begin : compare_bus
      trace_reg_pkg::byte_t expected;
      forever begin
         @(posedge usb_clk);
         // Selected means address valid with our window bits
         check_bit("selected", selected, reg_addrvalid && (reg_address[7:6] == WINDOW));
         if (reg_read) begin
            expected = exp_q.pop_front();
            @(negedge usb_clk);
            check_byte("read_data", read_data, expected);
         end
      end
   end

   initial begin : watchdog
      #(20 * TEST_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, run did not finish within %0d cycles", 20 * TEST_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin : stimulus
      trace_reg_pkg::reg_addr_t pat_addr;
      trace_reg_pkg::reg_addr_t msk_addr;
      lfsr_state    = 32'hea80;
      n_checks      = 0;
      n_errors      = 0;
      reset_i       = 1'b1;
      reg_address   = '0;
      reg_bytecnt   = '0;
      write_data    = '0;
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
      synchronized  = 1'b0;
      for (int r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin
         trace_counts[3'(r)] = '0;
      end
      model_reset();
      repeat (RESET_CYCLES) @(negedge usb_clk);
      reset_i = 1'b0;

      // Reset state on the outputs and over the bus
      check_bit("reset_sync", reset_sync, 1'b0);
      check_ctrl("trace_ctrl", trace_ctrl, sh_ctrl);
      check_rules();
      read_register_map();

      // Random contents for every rule, lane by lane
      for (int r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin
         pat_addr = trace_reg_pkg::REG_TRACE_PATTERN_BASE + 6'(r);
         msk_addr = trace_reg_pkg::REG_TRACE_MASK_BASE + 6'(r);
         for (int b = 0; b < 8; b++) begin
            bus_write(in_window(pat_addr), 7'(b), random_byte(), 1'b1);
            bus_write(in_window(msk_addr), 7'(b), random_byte(), 1'b1);
         end
      end
      bus_idle();
      check_rules();
      read_register_map();

      // Control fields, upper data bits set so truncation shows
      for (int k = 0; k < 4; k++) begin
         bus_write(in_window(trace_reg_pkg::REG_PATTERN_ENABLE), 7'(k), random_byte(), 1'b1);
         bus_write(in_window(trace_reg_pkg::REG_PATTERN_TRIG_ENABLE), 7'(k), random_byte(), 1'b1);
         bus_write(in_window(trace_reg_pkg::REG_TRACE_WIDTH), 7'(k), random_byte() | 8'hf8, 1'b1);
         bus_write(in_window(trace_reg_pkg::REG_CAPTURE_RAW), 7'(k + 8), random_byte() | 8'hfe, 1'b1);
         bus_write(in_window(trace_reg_pkg::REG_RECORD_SYNCS), 7'(k), random_byte() | 8'hfe, 1'b1);
         bus_idle();
         check_ctrl("trace_ctrl", trace_ctrl, sh_ctrl);
         for (int a = 2; a <= 6; a++) begin
            bus_read(in_window(6'(a)), 7'(k), 1'b1);
         end
      end

      // Resync write held for three cycles, sampled before each new drive
      for (int c = 0; c < 6; c++) begin
         @(negedge usb_clk);
         check_bit("reset_sync", reset_sync, c == 1);
         reg_address   = in_window(trace_reg_pkg::REG_TRACE_RESET_SYNC);
         reg_bytecnt   = '0;
         write_data    = random_byte();
         reg_addrvalid = 1'b1;
         reg_read      = 1'b0;
         reg_write     = (c < 3);
      end

      // Wrong window or no address valid, data always differs from the stored byte
      bus_write({2'd1, trace_reg_pkg::REG_TRACE_WIDTH}, 7'd0, {5'd0, ~sh_ctrl.trace_width}, 1'b1);
      bus_write(in_window(trace_reg_pkg::REG_CAPTURE_RAW), 7'd0, {7'd0, ~sh_ctrl.capture_raw}, 1'b0);
      bus_write({2'd3, trace_reg_pkg::REG_TRACE_PATTERN_BASE}, 7'd2, ~sh_pattern[0][23:16], 1'b1);
      bus_write(in_window(trace_reg_pkg::REG_TRACE_MASK_BASE), 7'd1, ~sh_mask[0][15:8], 1'b0);
      bus_idle();
      check_ctrl("trace_ctrl", trace_ctrl, sh_ctrl);
      check_rules();
      bus_read({2'd1, trace_reg_pkg::REG_REV}, 7'd0, 1'b1);
      bus_read(in_window(trace_reg_pkg::REG_NAME), 7'd0, 1'b0);
      bus_read({2'd0, trace_reg_pkg::REG_TRACE_PATTERN_BASE}, 7'd0, 1'b1);
      bus_idle();

      // Trace counts come back last rule first
      for (int r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin
         trace_counts[3'(r)] = random_byte();
      end
      synchronized = 1'b1;
      for (int b = 0; b < 8; b++) begin
         bus_read(in_window(trace_reg_pkg::REG_TRACE_COUNT), 7'(b), 1'b1);
      end
      bus_read(in_window(trace_reg_pkg::REG_SYNCHRONIZED), 7'd0, 1'b1);
      bus_idle();
      synchronized = 1'b0;
      bus_read(in_window(trace_reg_pkg::REG_SYNCHRONIZED), 7'd0, 1'b1);
      bus_idle();
      bus_idle();

      if (exp_q.size() != 0) begin
         $display("%0d read results were never checked", exp_q.size());
         n_errors++;
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All tests passed");
      end
      else begin
         $display("Some tests failed");
      end
      $finish;
   end

   `include "trace_reg_tb_tasks.svh"

endmodule

`default_nettype wire

/* verilog/match_rule_regs.sv */
// One match rule; byte lanes are written one at a time, no wider write path exists
`default_nettype none

module match_rule_regs (
   input  wire                         usb_clk,
   input  wire                         reset_i,
   input  wire                         pattern_we,
   input  wire                         mask_we,
   input  wire trace_reg_pkg::lane_t   lane,
   input  wire trace_reg_pkg::byte_t   wdata,

   output trace_reg_pkg::pattern_t     pattern,
   output trace_reg_pkg::pattern_t     mask
);

   logic [5:0] bit_base;   // First bit of the addressed lane

   assign bit_base = {lane, 3'b000};

   ////////////////////
   // Pattern and mask storage
   ////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         pattern <= trace_reg_pkg::PATTERN_RESET;
         mask    <= trace_reg_pkg::MASK_RESET;   // Match anything until programmed
      end
      else begin
         if (pattern_we) begin
            pattern[bit_base +: 8] <= wdata;
         end
         if (mask_we) begin
            mask[bit_base +: 8] <= wdata;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/trace_ctrl_regs.sv */
// Trace control registers; only the low bits that fit each field are kept, resync is write-only
`default_nettype none

module trace_ctrl_regs (
   input  wire                           usb_clk,
   input  wire                           reset_i,
   input  wire trace_reg_pkg::reg_req_t  req,

   output trace_reg_pkg::trace_ctrl_t    ctrl,
   output logic                          reset_sync
);

   logic resync_hit;
   logic resync_q;     // Write seen last cycle
   logic resync_qq;

   ////////////////////
   // Control registers
   ////////////////////

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         ctrl.pattern_enable      <= trace_reg_pkg::ENABLE_RESET;
         ctrl.pattern_trig_enable <= trace_reg_pkg::ENABLE_RESET;
         ctrl.trace_width         <= trace_reg_pkg::TRACE_WIDTH_RESET;
         ctrl.capture_raw         <= trace_reg_pkg::CAPTURE_RAW_RESET;
         ctrl.record_syncs        <= trace_reg_pkg::RECORD_SYNCS_RESET;
      end
      else if (req.write) begin
         case (req.addr)
            trace_reg_pkg::REG_PATTERN_ENABLE: begin
               ctrl.pattern_enable <= req.wdata[trace_reg_pkg::MAX_RULES-1:0];
            end
            trace_reg_pkg::REG_PATTERN_TRIG_ENABLE: begin
               ctrl.pattern_trig_enable <= req.wdata[trace_reg_pkg::MAX_RULES-1:0];
            end
            trace_reg_pkg::REG_TRACE_WIDTH: begin
               ctrl.trace_width <= req.wdata[2:0];   // Lane count, 1 to 4 in practice
            end
            trace_reg_pkg::REG_CAPTURE_RAW: begin
               ctrl.capture_raw <= req.wdata[0];
            end
            trace_reg_pkg::REG_RECORD_SYNCS: begin
               ctrl.record_syncs <= req.wdata[0];
            end
            default: begin
               // Rule registers and read-only addresses live elsewhere
            end
         endcase
      end
   end

   ////////////////////
   // Resync pulse
   ////////////////////

   assign resync_hit = req.write && (req.addr == trace_reg_pkg::REG_TRACE_RESET_SYNC);

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         resync_q  <= 1'b0;
         resync_qq <= 1'b0;
      end
      else begin
         resync_q  <= resync_hit;
         resync_qq <= resync_q;
      end
   end

   // Rising edge only, so a burst of writes still gives one pulse
   assign reset_sync = resync_q && !resync_qq;

endmodule

`default_nettype wire

/* verilog/trace_read_mux.sv */
// Read path; unknown addresses and rule slots past N_RULES read 0, output register has no reset
`default_nettype none

module trace_read_mux #(
   parameter int N_RULES         = 8,
   parameter bit REGISTERED_READ = 1'b1
)(
   input  wire                              usb_clk,
   input  wire trace_reg_pkg::reg_req_t     req,
   input  wire trace_reg_pkg::trace_ctrl_t  ctrl,
   input  wire trace_reg_pkg::pattern_t     patterns [trace_reg_pkg::MAX_RULES],
   input  wire trace_reg_pkg::pattern_t     masks [trace_reg_pkg::MAX_RULES],
   input  wire trace_reg_pkg::byte_t        trace_counts [trace_reg_pkg::MAX_RULES],
   input  wire                              synchronized,

   output trace_reg_pkg::byte_t             read_data
);

   logic [2:0]           rule;         // Rule slot of a pattern or mask address
   logic [2:0]           count_rule;   // Counts come out last rule first
   logic [5:0]           bit_base;
   trace_reg_pkg::byte_t rd_comb;

   assign rule       = req.addr[2:0];
   assign count_rule = 3'd7 - req.lane;
   assign bit_base   = {req.lane, 3'b000};

   ////////////////////
   // Byte select
   ////////////////////

   always_comb begin
      rd_comb = '0;
      if (req.read) begin
         case (req.addr)
            trace_reg_pkg::REG_NAME:
               rd_comb = trace_reg_pkg::TRACE_NAME[bit_base +: 8];
            trace_reg_pkg::REG_REV:
               rd_comb = trace_reg_pkg::TRACE_REV;
            trace_reg_pkg::REG_PATTERN_ENABLE:
               rd_comb = ctrl.pattern_enable;
            trace_reg_pkg::REG_PATTERN_TRIG_ENABLE:
               rd_comb = ctrl.pattern_trig_enable;
            trace_reg_pkg::REG_TRACE_WIDTH:
               rd_comb = {5'd0, ctrl.trace_width};
            trace_reg_pkg::REG_CAPTURE_RAW:
               rd_comb = {7'd0, ctrl.capture_raw};
            trace_reg_pkg::REG_RECORD_SYNCS:
               rd_comb = {7'd0, ctrl.record_syncs};
            trace_reg_pkg::REG_SYNCHRONIZED:
               rd_comb = {7'd0, synchronized};
            trace_reg_pkg::REG_TRACE_COUNT: begin
               if (int'(count_rule) < N_RULES) begin
                  rd_comb = trace_counts[count_rule];
               end
            end
            default: begin
               // Rule ranges are 8-aligned blocks
               if (int'(rule) < N_RULES) begin
                  if (req.addr[5:3] == trace_reg_pkg::REG_TRACE_PATTERN_BASE[5:3]) begin
                     rd_comb = patterns[rule][bit_base +: 8];
                  end
                  else if (req.addr[5:3] == trace_reg_pkg::REG_TRACE_MASK_BASE[5:3]) begin
                     rd_comb = masks[rule][bit_base +: 8];
                  end
               end
            end
         endcase
      end
   end

   ////////////////////
   // Output stage
   ////////////////////

   generate
      if (REGISTERED_READ) begin : g_read_reg
         trace_reg_pkg::byte_t read_data_r;

         always_ff @(posedge usb_clk) begin
            read_data_r <= rd_comb;   // Zero whenever no read was asked for
         end

         assign read_data = read_data_r;
      end
      else begin : g_read_comb
         assign read_data = rd_comb;   // Same-cycle data
      end
   endgenerate

endmodule

`default_nettype wire

/* verilog/trace_reg_block.sv */
// Trace sniffer register block; N_RULES 1..8, slots past it read 0 and output reset values
`default_nettype none

module trace_reg_block #(
   parameter int         N_RULES         = 8,
   parameter logic [1:0] BLOCK_SELECT    = 2'd2,
   parameter bit         REGISTERED_READ = 1'b1
)(
   input  wire                              usb_clk,
   input  wire                              reset_i,

   // Host register bus
   input  wire trace_reg_pkg::byte_t        reg_address,
   input  wire trace_reg_pkg::byte_idx_t    reg_bytecnt,
   input  wire trace_reg_pkg::byte_t        write_data,
   input  wire                              reg_read,
   input  wire                              reg_write,
   input  wire                              reg_addrvalid,
   output trace_reg_pkg::byte_t             read_data,
   output logic                             selected,

   // Trace core side
   output trace_reg_pkg::trace_ctrl_t       trace_ctrl,
   output trace_reg_pkg::pattern_t          trace_patterns [trace_reg_pkg::MAX_RULES],
   output trace_reg_pkg::pattern_t          trace_masks [trace_reg_pkg::MAX_RULES],
   output logic                             reset_sync,
   input  wire trace_reg_pkg::byte_t        trace_counts [trace_reg_pkg::MAX_RULES],
   input  wire                              synchronized
);

   trace_reg_pkg::reg_req_t  req;
   trace_reg_pkg::rule_vec_t pattern_we;
   trace_reg_pkg::rule_vec_t mask_we;

   trace_reg_decode #(
      .N_RULES      (N_RULES),
      .BLOCK_SELECT (BLOCK_SELECT)
   ) i_decode (
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .write_data    (write_data),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .reg_addrvalid (reg_addrvalid),
      .selected      (selected),
      .req           (req),
      .pattern_we    (pattern_we),
      .mask_we       (mask_we)
   );

   trace_ctrl_regs i_ctrl (
      .usb_clk    (usb_clk),
      .reset_i    (reset_i),
      .req        (req),
      .ctrl       (trace_ctrl),
      .reset_sync (reset_sync)
   );

   ////////////////////
   // Rule slices
   ////////////////////

   generate
      for (genvar r = 0; r < trace_reg_pkg::MAX_RULES; r++) begin : g_rule
         if (r < N_RULES) begin : g_slice
            match_rule_regs i_rule (
               .usb_clk    (usb_clk),
               .reset_i    (reset_i),
               .pattern_we (pattern_we[r]),
               .mask_we    (mask_we[r]),
               .lane       (req.lane),
               .wdata      (req.wdata),
               .pattern    (trace_patterns[r]),
               .mask       (trace_masks[r])
            );
         end
         else begin : g_absent
            // Unbuilt slot looks like a rule that was never programmed
            assign trace_patterns[r] = trace_reg_pkg::PATTERN_RESET;
            assign trace_masks[r]    = trace_reg_pkg::MASK_RESET;
         end
      end
   endgenerate

   trace_read_mux #(
      .N_RULES         (N_RULES),
      .REGISTERED_READ (REGISTERED_READ)
   ) i_read_mux (
      .usb_clk      (usb_clk),
      .req          (req),
      .ctrl         (trace_ctrl),
      .patterns     (trace_patterns),
      .masks        (trace_masks),
      .trace_counts (trace_counts),
      .synchronized (synchronized),
      .read_data    (read_data)
   );

endmodule

`default_nettype wire

/* verilog/trace_reg_decode.sv */
// Combinational window decode; N_RULES must lie in 1..8, strobes for rules past it stay low
`default_nettype none

module trace_reg_decode #(
   parameter int         N_RULES      = 8,
   parameter logic [1:0] BLOCK_SELECT = 2'd2
)(
   input  wire trace_reg_pkg::byte_t     reg_address,
   input  wire trace_reg_pkg::byte_idx_t reg_bytecnt,
   input  wire trace_reg_pkg::byte_t     write_data,
   input  wire                           reg_read,
   input  wire                           reg_write,
   input  wire                           reg_addrvalid,

   output logic                          selected,
   output trace_reg_pkg::reg_req_t       req,
   output trace_reg_pkg::rule_vec_t      pattern_we,
   output trace_reg_pkg::rule_vec_t      mask_we
);

   trace_reg_pkg::reg_addr_t offset;
   logic [2:0]               rule;        // Rule slot inside a pattern or mask range
   logic                     rule_valid;
   logic                     pattern_hit;
   logic                     mask_hit;

   ////////////////////
   // Window select
   ////////////////////

   assign selected = reg_addrvalid && (reg_address[7:6] == BLOCK_SELECT);
   assign offset   = reg_address[5:0];

   always_comb begin
      req.addr  = offset;
      req.lane  = reg_bytecnt[2:0];   // Upper counter bits wrap onto lanes
      req.wdata = write_data;
      req.write = selected && reg_write;
      req.read  = selected && reg_read;
   end

   ////////////////////
   // Rule strobes
   ////////////////////

   assign rule       = offset[2:0];
   assign rule_valid = (int'(rule) < N_RULES);

   // Pattern and mask ranges are 8-aligned, so the upper bits name the range
   assign pattern_hit = req.write && rule_valid &&
                        (offset[5:3] == trace_reg_pkg::REG_TRACE_PATTERN_BASE[5:3]);
   assign mask_hit    = req.write && rule_valid &&
                        (offset[5:3] == trace_reg_pkg::REG_TRACE_MASK_BASE[5:3]);

   // One-hot, at most one bit per strobe
   always_comb begin
      pattern_we = '0;
      mask_we    = '0;
      if (pattern_hit) begin
         pattern_we[rule] = 1'b1;
      end
      if (mask_hit) begin
         mask_we[rule] = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verilog/trace_reg_pkg.sv */
// Shared types and address map of the trace register block; at most 8 rules, 64-bit rule registers
`default_nettype none

package trace_reg_pkg;

   ////////////////////
   // Widths and types
   ////////////////////

   typedef logic [7:0]  byte_t;       // One register bus byte
   typedef logic [5:0]  reg_addr_t;   // Offset inside the 64-register window
   typedef logic [6:0]  byte_idx_t;   // Host byte counter, low 3 bits pick the lane
   typedef logic [2:0]  lane_t;
   typedef logic [63:0] pattern_t;    // Rule pattern or mask

   localparam int MAX_RULES = 8;

   typedef logic [MAX_RULES-1:0] rule_vec_t;   // One bit per rule slot
   typedef logic [2:0]           trace_width_t;

   // Request as seen by the register slices, already qualified by window select
   typedef struct packed {
      reg_addr_t addr;
      lane_t     lane;
      byte_t     wdata;
      logic      write;
      logic      read;
   } reg_req_t;

   typedef struct packed {
      rule_vec_t    pattern_enable;
      rule_vec_t    pattern_trig_enable;
      trace_width_t trace_width;
      logic         capture_raw;
      logic         record_syncs;
   } trace_ctrl_t;

   ////////////////////
   // Address map
   ////////////////////

   localparam reg_addr_t REG_NAME                = 6'd0;
   localparam reg_addr_t REG_REV                 = 6'd1;
   localparam reg_addr_t REG_PATTERN_ENABLE      = 6'd2;
   localparam reg_addr_t REG_PATTERN_TRIG_ENABLE = 6'd3;
   localparam reg_addr_t REG_TRACE_WIDTH         = 6'd4;
   localparam reg_addr_t REG_CAPTURE_RAW         = 6'd5;
   localparam reg_addr_t REG_RECORD_SYNCS        = 6'd6;
   localparam reg_addr_t REG_TRACE_RESET_SYNC    = 6'd7;   // Write only, any data
   localparam reg_addr_t REG_SYNCHRONIZED        = 6'd8;
   localparam reg_addr_t REG_TRACE_COUNT         = 6'd9;
   localparam reg_addr_t REG_TRACE_PATTERN_BASE  = 6'd16;  // Rules at 16..23
   localparam reg_addr_t REG_TRACE_MASK_BASE     = 6'd24;  // Rules at 24..31

   ////////////////////
   // Constants and reset values
   ////////////////////

   // "ArmTrace" with 'A' in byte 0
   localparam pattern_t TRACE_NAME = 64'h6563_6172_546d_7241;
   localparam byte_t    TRACE_REV  = 8'h01;

   localparam trace_width_t TRACE_WIDTH_RESET  = 3'd4;   // 4-lane trace by default
   localparam logic         CAPTURE_RAW_RESET  = 1'b1;
   localparam logic         RECORD_SYNCS_RESET = 1'b0;
   localparam rule_vec_t    ENABLE_RESET       = '0;
   localparam pattern_t     PATTERN_RESET      = '0;
   localparam pattern_t     MASK_RESET         = '1;     // Don't-care on every bit

endpackage

`default_nettype wire
